/* source/mem_unit_pkg.sv */
// Address map, bus widths and region codes shared by the memory unit RTL and its testbench
package mem_unit_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int BUS_AW     = 27;
    localparam int BUS_DW     = 32;
    localparam int VRAM_AW    = 14;
    localparam int VRAM8_DW   = 8;
    localparam int VRAMSPR_DW = 9;
    localparam int ROM_AW     = 9;

    // CPU side
    typedef logic [BUS_AW-1:0]     bus_addr_t;
    typedef logic [BUS_DW-1:0]     bus_data_t;

    // Memory side
    typedef logic [VRAM_AW-1:0]    vram_addr_t;
    typedef logic [VRAM8_DW-1:0]   vram8_data_t;
    typedef logic [VRAMSPR_DW-1:0] vramspr_data_t;
    typedef logic [ROM_AW-1:0]     rom_addr_t;

    // --------------------------------------------------
    // Access targets
    // --------------------------------------------------
    // Unmapped addresses fall into REGION_NONE and complete with zero
    typedef enum logic [2:0] {
        REGION_NONE    = 3'd0,
        REGION_VRAM32  = 3'd1,
        REGION_VRAM8   = 3'd2,
        REGION_VRAMSPR = 3'd3,
        REGION_ROM     = 3'd4,
        REGION_GPIO    = 3'd5,
        REGION_BOOT    = 3'd6
    } region_t;

    // --------------------------------------------------
    // Address map
    // --------------------------------------------------
    // Word memory, 0x420 words
    localparam bus_addr_t VRAM32_BASE  = 27'hC00000;

    // Tile memory, 0x2002 words
    localparam bus_addr_t VRAM8_BASE   = 27'hC00420;

    // Sprite memory, 0x100 words
    localparam bus_addr_t VRAMSPR_BASE = 27'hC02422;

    // ROM, 0x200 words up to ROM_END exclusive
    localparam bus_addr_t ROM_BASE     = 27'hC02522;
    localparam bus_addr_t ROM_END      = 27'hC02722;

    // Single registers
    localparam bus_addr_t GPIO_ADDR    = 27'hC02737;
    localparam bus_addr_t BOOT_ADDR    = 27'hC02741;

endpackage

/* source/bus_decoder.sv */
// Combinational address decode from a CPU bus address to a target region and window offset
`timescale 1ns/1ps

module bus_decoder
(
    input  mem_unit_pkg::bus_addr_t  i_bus_addr,
    output mem_unit_pkg::region_t    o_region,
    output mem_unit_pkg::vram_addr_t o_offset
);

    // Base of the matched window, zero for registers and unmapped space
    mem_unit_pkg::bus_addr_t base;
    mem_unit_pkg::bus_addr_t window_off;
    logic                    in_window;

    // --------------------------------------------------
    // Region match
    // --------------------------------------------------
    always_comb
    begin
        o_region  = mem_unit_pkg::REGION_NONE;
        base      = '0;
        in_window = 1'b0;

        if (i_bus_addr >= mem_unit_pkg::VRAM32_BASE && i_bus_addr < mem_unit_pkg::VRAM8_BASE)
        begin
            o_region  = mem_unit_pkg::REGION_VRAM32;
            base      = mem_unit_pkg::VRAM32_BASE;
            in_window = 1'b1;
        end
        else if (i_bus_addr >= mem_unit_pkg::VRAM8_BASE &&
                 i_bus_addr < mem_unit_pkg::VRAMSPR_BASE)
        begin
            o_region  = mem_unit_pkg::REGION_VRAM8;
            base      = mem_unit_pkg::VRAM8_BASE;
            in_window = 1'b1;
        end
        else if (i_bus_addr >= mem_unit_pkg::VRAMSPR_BASE &&
                 i_bus_addr < mem_unit_pkg::ROM_BASE)
        begin
            o_region  = mem_unit_pkg::REGION_VRAMSPR;
            base      = mem_unit_pkg::VRAMSPR_BASE;
            in_window = 1'b1;
        end
        else if (i_bus_addr >= mem_unit_pkg::ROM_BASE && i_bus_addr < mem_unit_pkg::ROM_END)
        begin
            o_region  = mem_unit_pkg::REGION_ROM;
            base      = mem_unit_pkg::ROM_BASE;
            in_window = 1'b1;
        end
        else if (i_bus_addr == mem_unit_pkg::GPIO_ADDR)
        begin
            o_region = mem_unit_pkg::REGION_GPIO;
        end
        else if (i_bus_addr == mem_unit_pkg::BOOT_ADDR)
        begin
            o_region = mem_unit_pkg::REGION_BOOT;
        end
    end

    // --------------------------------------------------
    // Window offset
    // --------------------------------------------------
    assign window_off = i_bus_addr - base;

    // Largest window is the tile memory, which still fits in 14 bits
    assign o_offset = in_window ? window_off[mem_unit_pkg::VRAM_AW-1:0] : '0;

    // Region code always one of the defined targets
    always_comb
    begin
        assert (o_region inside {mem_unit_pkg::REGION_NONE, mem_unit_pkg::REGION_VRAM32,
                                 mem_unit_pkg::REGION_VRAM8, mem_unit_pkg::REGION_VRAMSPR,
                                 mem_unit_pkg::REGION_ROM, mem_unit_pkg::REGION_GPIO,
                                 mem_unit_pkg::REGION_BOOT})
        else $error("bus_decoder: undefined region code %0d", o_region);
    end

endmodule

/* source/request_stage.sv */
// One-entry request buffer that accepts a bus access, drives the memory ports and holds GPO
`timescale 1ns/1ps

module request_stage
#(
    parameter int GPIO_W = 4
)
(
    input  logic                        clk,
    input  logic                        reset,

    // Bus request and decode
    input  logic                        i_bus_start,
    input  logic                        i_bus_we,
    input  mem_unit_pkg::region_t       i_region,
    input  mem_unit_pkg::vram_addr_t    i_offset,
    input  mem_unit_pkg::bus_data_t     i_bus_data,
    input  logic                        i_done,

    // To response stage
    output mem_unit_pkg::region_t       o_held_region,
    output logic                        o_accept,

    // Word memory
    output mem_unit_pkg::vram_addr_t    o_vram32_addr,
    output mem_unit_pkg::bus_data_t     o_vram32_d,
    output logic                        o_vram32_we,

    // Tile memory
    output mem_unit_pkg::vram_addr_t    o_vram8_addr,
    output mem_unit_pkg::vram8_data_t   o_vram8_d,
    output logic                        o_vram8_we,

    // Sprite memory
    output mem_unit_pkg::vram_addr_t    o_vramspr_addr,
    output mem_unit_pkg::vramspr_data_t o_vramspr_d,
    output logic                        o_vramspr_we,

    // ROM
    output mem_unit_pkg::rom_addr_t     o_rom_addr,

    // General outputs
    output logic [GPIO_W-1:0]           o_gpo
);

    logic busy;
    logic write_accept;

    // --------------------------------------------------
    // Accept rule
    // --------------------------------------------------
    // A start held through done is ignored until the edge after done
    assign o_accept     = i_bus_start && !busy && !i_done;
    assign write_accept = o_accept && i_bus_we;

    // Busy covers the cycle in which the memories return data
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy          <= 1'b0;
            o_held_region <= mem_unit_pkg::REGION_NONE;
        end
        else if (o_accept)
        begin
            busy          <= 1'b1;
            o_held_region <= i_region;
        end
        else
        begin
            busy <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Memory ports
    // --------------------------------------------------
    // Address and data follow the decoder, only the write enable is gated
    assign o_vram32_addr  = i_offset;
    assign o_vram32_d     = i_bus_data;
    assign o_vram32_we    = write_accept && (i_region == mem_unit_pkg::REGION_VRAM32);

    assign o_vram8_addr   = i_offset;
    assign o_vram8_d      = i_bus_data[mem_unit_pkg::VRAM8_DW-1:0];
    assign o_vram8_we     = write_accept && (i_region == mem_unit_pkg::REGION_VRAM8);

    assign o_vramspr_addr = i_offset;
    assign o_vramspr_d    = i_bus_data[mem_unit_pkg::VRAMSPR_DW-1:0];
    assign o_vramspr_we   = write_accept && (i_region == mem_unit_pkg::REGION_VRAMSPR);

    assign o_rom_addr     = i_offset[mem_unit_pkg::ROM_AW-1:0];

    // --------------------------------------------------
    // GPIO output register
    // --------------------------------------------------
    // New outputs come from the field above the inputs in the read layout
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            o_gpo <= '0;
        end
        else if (write_accept && i_region == mem_unit_pkg::REGION_GPIO)
        begin
            o_gpo <= i_bus_data[2*GPIO_W-1:GPIO_W];
        end
    end

    // Accepts are separated by at least the busy cycle
    assert property (@(posedge clk) disable iff (reset) o_accept |=> !o_accept)
    else $error("request_stage: accept while busy");

    assert property (@(posedge clk) disable iff (reset)
                     $onehot0({o_vram32_we, o_vram8_we, o_vramspr_we}))
    else $error("request_stage: more than one write enable");

endmodule

/* source/response_stage.sv */
// Response stage that forms the read value for the held region and pulses bus done
`timescale 1ns/1ps

module response_stage
#(
    parameter int GPIO_W = 4
)
(
    input  logic                        clk,
    input  logic                        reset,

    // From request stage
    input  logic                        i_accept,
    input  mem_unit_pkg::region_t       i_held_region,

    // Memory read data, valid the cycle after the accept edge
    input  mem_unit_pkg::bus_data_t     i_vram32_q,
    input  mem_unit_pkg::vram8_data_t   i_vram8_q,
    input  mem_unit_pkg::vramspr_data_t i_vramspr_q,
    input  mem_unit_pkg::bus_data_t     i_rom_q,

    // Register sources
    input  logic [GPIO_W-1:0]           i_gpi,
    input  logic [GPIO_W-1:0]           i_gpo,
    input  logic                        i_boot_mode,

    // Bus response
    output mem_unit_pkg::bus_data_t     o_bus_q,
    output logic                        o_bus_done
);

    // High in the cycle where memory data is valid
    logic                    data_phase;
    mem_unit_pkg::bus_data_t rd_value;

    // --------------------------------------------------
    // Read value select
    // --------------------------------------------------
    always_comb
    begin
        rd_value = '0;
        case (i_held_region)
            mem_unit_pkg::REGION_VRAM32:
            begin
                rd_value = i_vram32_q;
            end
            mem_unit_pkg::REGION_VRAM8:
            begin
                rd_value[mem_unit_pkg::VRAM8_DW-1:0] = i_vram8_q;
            end
            mem_unit_pkg::REGION_VRAMSPR:
            begin
                rd_value[mem_unit_pkg::VRAMSPR_DW-1:0] = i_vramspr_q;
            end
            mem_unit_pkg::REGION_ROM:
            begin
                rd_value = i_rom_q;
            end
            mem_unit_pkg::REGION_GPIO:
            begin
                // Inputs low, outputs right above them
                rd_value[GPIO_W-1:0]        = i_gpi;
                rd_value[2*GPIO_W-1:GPIO_W] = i_gpo;
            end
            mem_unit_pkg::REGION_BOOT:
            begin
                rd_value[0] = i_boot_mode;
            end
            default:
            begin
                rd_value = '0;
            end
        endcase
    end

    // --------------------------------------------------
    // Done pulse and read register
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            data_phase <= 1'b0;
            o_bus_done <= 1'b0;
            o_bus_q    <= '0;
        end
        else
        begin
            data_phase <= i_accept;
            o_bus_done <= data_phase;
            if (data_phase)
            begin
                o_bus_q <= rd_value;
            end
        end
    end

    // Done feeds back into the accept rule, so it never stretches
    assert property (@(posedge clk) disable iff (reset) o_bus_done |=> !o_bus_done)
    else $error("response_stage: done high for two cycles");

endmodule

/* source/memory_unit.sv */
// Top level of the CPU-facing memory unit bus, connecting decode, request and response stages
`timescale 1ns/1ps

module memory_unit
#(
    parameter int GPIO_W = 4
)
(
    input  logic                        clk,
    input  logic                        reset,

    // CPU bus
    input  mem_unit_pkg::bus_addr_t     i_bus_addr,
    input  mem_unit_pkg::bus_data_t     i_bus_data,
    input  logic                        i_bus_we,
    input  logic                        i_bus_start,
    output mem_unit_pkg::bus_data_t     o_bus_q,
    output logic                        o_bus_done,

    // Word memory CPU port
    output mem_unit_pkg::vram_addr_t    o_vram32_addr,
    output mem_unit_pkg::bus_data_t     o_vram32_d,
    output logic                        o_vram32_we,
    input  mem_unit_pkg::bus_data_t     i_vram32_q,

    // Tile memory CPU port
    output mem_unit_pkg::vram_addr_t    o_vram8_addr,
    output mem_unit_pkg::vram8_data_t   o_vram8_d,
    output logic                        o_vram8_we,
    input  mem_unit_pkg::vram8_data_t   i_vram8_q,

    // Sprite memory CPU port
    output mem_unit_pkg::vram_addr_t    o_vramspr_addr,
    output mem_unit_pkg::vramspr_data_t o_vramspr_d,
    output logic                        o_vramspr_we,
    input  mem_unit_pkg::vramspr_data_t i_vramspr_q,

    // ROM
    output mem_unit_pkg::rom_addr_t     o_rom_addr,
    input  mem_unit_pkg::bus_data_t     i_rom_q,

    // GPIO and boot mode
    input  logic [GPIO_W-1:0]           i_gpi,
    output logic [GPIO_W-1:0]           o_gpo,
    input  logic                        i_boot_mode
);

    mem_unit_pkg::region_t    region;
    mem_unit_pkg::vram_addr_t offset;
    mem_unit_pkg::region_t    held_region;
    logic                     accept;

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------
    bus_decoder u_bus_decoder
    (
        .i_bus_addr (i_bus_addr),
        .o_region   (region),
        .o_offset   (offset)
    );

    // --------------------------------------------------
    // Request buffer and memory ports
    // --------------------------------------------------
    request_stage #(
        .GPIO_W (GPIO_W)
    ) u_request_stage (
        .clk            (clk),
        .reset          (reset),
        .i_bus_start    (i_bus_start),
        .i_bus_we       (i_bus_we),
        .i_region       (region),
        .i_offset       (offset),
        .i_bus_data     (i_bus_data),
        .i_done         (o_bus_done),
        .o_held_region  (held_region),
        .o_accept       (accept),
        .o_vram32_addr  (o_vram32_addr),
        .o_vram32_d     (o_vram32_d),
        .o_vram32_we    (o_vram32_we),
        .o_vram8_addr   (o_vram8_addr),
        .o_vram8_d      (o_vram8_d),
        .o_vram8_we     (o_vram8_we),
        .o_vramspr_addr (o_vramspr_addr),
        .o_vramspr_d    (o_vramspr_d),
        .o_vramspr_we   (o_vramspr_we),
        .o_rom_addr     (o_rom_addr),
        .o_gpo          (o_gpo)
    );

    // --------------------------------------------------
    // Read data and done
    // --------------------------------------------------
    response_stage #(
        .GPIO_W (GPIO_W)
    ) u_response_stage (
        .clk           (clk),
        .reset         (reset),
        .i_accept      (accept),
        .i_held_region (held_region),
        .i_vram32_q    (i_vram32_q),
        .i_vram8_q     (i_vram8_q),
        .i_vramspr_q   (i_vramspr_q),
        .i_rom_q       (i_rom_q),
        .i_gpi         (i_gpi),
        .i_gpo         (o_gpo),
        .i_boot_mode   (i_boot_mode),
        .o_bus_q       (o_bus_q),
        .o_bus_done    (o_bus_done)
    );

endmodule

/* bench/tb_checks.svh */
// Compare tasks for the memory unit testbench, included inside the testbench top module
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// --------------------------------------------------
// Read data
// --------------------------------------------------
task automatic check_bus_q(input mem_unit_pkg::bus_data_t got,
                           input mem_unit_pkg::bus_data_t exp,
                           input string                   what);
    if (got !== exp)
    begin
        $display("MISMATCH at %0d ns: %s returned %h, expected %h", $time, what, got, exp);
        abort_run();
    end
endtask

// --------------------------------------------------
// General outputs
// --------------------------------------------------
task automatic check_gpo(input logic [GPIO_W-1:0] got,
                         input logic [GPIO_W-1:0] exp,
                         input string             what);
    if (got !== exp)
    begin
        $display("MISMATCH at %0d ns: %s left o_gpo at %h, expected %h", $time, what, got, exp);
        abort_run();
    end
endtask

// --------------------------------------------------
// Done timing
// --------------------------------------------------
// Cycle counts for latency, pulse width and stray pulses
task automatic check_done_latency(input int    got,
                                  input int    exp,
                                  input string what);
    if (got != exp)
    begin
        $display("MISMATCH at %0d ns: %s is %0d cycles, expected %0d", $time, what, got, exp);
        abort_run();
    end
endtask

// --------------------------------------------------
// Memory write enables
// --------------------------------------------------
// Write enable samples summed over the three video memories
task automatic check_we_count(input int    got,
                              input int    exp,
                              input string what);
    if (got != exp)
    begin
        $display("MISMATCH at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        abort_run();
    end
endtask

`endif

/* bench/tb_memory_unit.sv */
// Testbench for the memory unit bus, replays the test data file against memory models
`timescale 1ns/1ps

module tb_memory_unit;

    localparam int GPIO_W            = 4;
    localparam int RESET_CYCLES      = 10;
    localparam int MAX_ACCESS        = 256;
    localparam int VRAM_DEPTH        = 1 << mem_unit_pkg::VRAM_AW;
    localparam int ROM_DEPTH         = 1 << mem_unit_pkg::ROM_AW;
    // Drive edge, accept on the next edge, done one edge later, seen at its negedge
    localparam int DONE_LATENCY      = 3;
    localparam int DONE_WAIT_MAX     = 16;
    localparam int CYCLES_PER_ACCESS = 8;
    localparam logic [31:0] END_MARK = 32'hFFFF_FFFF;

    logic                        clk = 1'b0;
    logic                        reset;
    mem_unit_pkg::bus_addr_t     bus_addr;
    mem_unit_pkg::bus_data_t     bus_data;
    logic                        bus_we;
    logic                        bus_start;
    mem_unit_pkg::bus_data_t     bus_q;
    logic                        bus_done;
    logic [GPIO_W-1:0]           gpi;
    logic [GPIO_W-1:0]           gpo;
    logic                        boot_mode;

    // Memory ports
    mem_unit_pkg::vram_addr_t    vram32_addr;
    mem_unit_pkg::bus_data_t     vram32_d;
    logic                        vram32_we;
    mem_unit_pkg::bus_data_t     vram32_q = '0;
    mem_unit_pkg::vram_addr_t    vram8_addr;
    mem_unit_pkg::vram8_data_t   vram8_d;
    logic                        vram8_we;
    mem_unit_pkg::vram8_data_t   vram8_q = '0;
    mem_unit_pkg::vram_addr_t    vramspr_addr;
    mem_unit_pkg::vramspr_data_t vramspr_d;
    logic                        vramspr_we;
    mem_unit_pkg::vramspr_data_t vramspr_q = '0;
    mem_unit_pkg::rom_addr_t     rom_addr;
    mem_unit_pkg::bus_data_t     rom_q = '0;

    mem_unit_pkg::bus_data_t     vram32_mem  [0:VRAM_DEPTH-1];
    mem_unit_pkg::vram8_data_t   vram8_mem   [0:VRAM_DEPTH-1];
    mem_unit_pkg::vramspr_data_t vramspr_mem [0:VRAM_DEPTH-1];
    mem_unit_pkg::bus_data_t     rom_mem     [0:ROM_DEPTH-1];

    // Four words per access: op, address, write data, expected value
    logic [31:0] test_words [0:4*MAX_ACCESS-1];
    int          n_access;
    int          seed        = 56;
    int          cycle_count = 0;
    int          cycle_limit = 1000000;

    memory_unit #(
        .GPIO_W (GPIO_W)
    ) u_dut (
        .clk            (clk),
        .reset          (reset),
        .i_bus_addr     (bus_addr),
        .i_bus_data     (bus_data),
        .i_bus_we       (bus_we),
        .i_bus_start    (bus_start),
        .o_bus_q        (bus_q),
        .o_bus_done     (bus_done),
        .o_vram32_addr  (vram32_addr),
        .o_vram32_d     (vram32_d),
        .o_vram32_we    (vram32_we),
        .i_vram32_q     (vram32_q),
        .o_vram8_addr   (vram8_addr),
        .o_vram8_d      (vram8_d),
        .o_vram8_we     (vram8_we),
        .i_vram8_q      (vram8_q),
        .o_vramspr_addr (vramspr_addr),
        .o_vramspr_d    (vramspr_d),
        .o_vramspr_we   (vramspr_we),
        .i_vramspr_q    (vramspr_q),
        .o_rom_addr     (rom_addr),
        .i_rom_q        (rom_q),
        .i_gpi          (gpi),
        .o_gpo          (gpo),
        .i_boot_mode    (boot_mode)
    );

    // --------------------------------------------------
    // Synchronous memory models, read data one cycle after address
    // --------------------------------------------------
    always @(posedge clk)
    begin
        if (vram32_we)
            vram32_mem[vram32_addr] <= vram32_d;
        vram32_q <= vram32_mem[vram32_addr];
    end

    always @(posedge clk)
    begin
        if (vram8_we)
            vram8_mem[vram8_addr] <= vram8_d;
        vram8_q <= vram8_mem[vram8_addr];
    end

    always @(posedge clk)
    begin
        if (vramspr_we)
            vramspr_mem[vramspr_addr] <= vramspr_d;
        vramspr_q <= vramspr_mem[vramspr_addr];
    end

    always @(posedge clk)
    begin
        rom_q <= rom_mem[rom_addr];
    end

    always #2 clk = ~clk;

    // Run limit
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    `include "tb_checks.svh"

    task automatic load_testdata();
        for (int i = 0; i < 4*MAX_ACCESS; i++)
        begin
            test_words[i] = END_MARK;
        end
        $readmemh("bench/memory_unit_testdata.txt", test_words);
        n_access = 0;
        while (n_access < MAX_ACCESS && test_words[4*n_access] != END_MARK)
        begin
            n_access = n_access + 1;
        end
        if (n_access == 0)
        begin
            $display("The test data file holds no accesses");
            abort_run();
        end
    endtask

    // --------------------------------------------------
    // One bus access with its done timing checks
    // --------------------------------------------------
    task automatic run_access(input int idx);
        logic [31:0]             op;
        mem_unit_pkg::bus_addr_t addr;
        mem_unit_pkg::bus_data_t expected;
        logic                    done_seen;
        int                      cycles;
        int                      we_count;
        int                      we_expected;
        string                   what;
        op       = test_words[4*idx];
        addr     = test_words[4*idx+1][mem_unit_pkg::BUS_AW-1:0];
        expected = test_words[4*idx+3];
        if (op > 32'd1)
        begin
            $display("Test data line %0d has an unknown operation %h", idx, op);
            abort_run();
        end
        what = $sformatf("access %0d (%s at %h)", idx, (op == 32'd1) ? "write" : "read", addr);

        // The three video windows lie back to back from the word memory up to the ROM
        we_expected = (op == 32'd1 && addr >= mem_unit_pkg::VRAM32_BASE &&
                       addr < mem_unit_pkg::ROM_BASE) ? 1 : 0;

        @(posedge clk);
        bus_addr  <= addr;
        bus_data  <= test_words[4*idx+2];
        bus_we    <= (op == 32'd1);
        bus_start <= 1'b1;

        cycles    = 0;
        we_count  = 0;
        done_seen = 1'b0;
        while (!done_seen && cycles < DONE_WAIT_MAX)
        begin
            @(negedge clk);
            cycles    = cycles + 1;
            done_seen = bus_done;
            we_count  = we_count + int'(vram32_we) + int'(vram8_we) + int'(vramspr_we);
        end
        if (!done_seen)
        begin
            $display("%s got no o_bus_done within %0d cycles", what, DONE_WAIT_MAX);
            abort_run();
        end
        check_done_latency(cycles, DONE_LATENCY, {what, " done latency"});
        if (op == 32'd1)
            check_gpo(gpo, expected[GPIO_W-1:0], what);
        else
            check_bus_q(bus_q, expected, what);

        // Start still seen high on this edge, must not start a second access
        @(posedge clk);
        bus_start <= 1'b0;
        bus_we    <= 1'b0;
        @(negedge clk);
        we_count = we_count + int'(vram32_we) + int'(vram8_we) + int'(vramspr_we);
        check_done_latency(bus_done ? 2 : 1, 1, {what, " done width"});
        check_we_count(we_count, we_expected, {what, " write enable cycles"});
    endtask

    task automatic idle_cycles(input int n);
        int stray;
        stray = 0;
        repeat (n)
        begin
            @(negedge clk);
            if (bus_done)
                stray = stray + 1;
        end
        check_done_latency(stray, 0, "stray done pulses in idle gap");
    endtask

    initial
    begin
        int gap;
        reset     = 1'b1;
        bus_addr  = '0;
        bus_data  = '0;
        bus_we    = 1'b0;
        bus_start = 1'b0;
        gpi       = 4'b1010;
        boot_mode = 1'b1;
        // ROM word is its offset times 0x01010101
        for (int i = 0; i < ROM_DEPTH; i++)
        begin
            rom_mem[i] = 32'(i) * 32'h0101_0101;
        end
        load_testdata();
        cycle_limit = n_access * CYCLES_PER_ACCESS + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        for (int i = 0; i < n_access; i++)
        begin
            run_access(i);
            gap = $unsigned($random(seed)) % 4;
            idle_cycles(gap);
        end
        // Last access leaves no second done behind
        idle_cycles(1);
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* bench/memory_unit_testdata.txt */
// Columns: op (0 read, 1 write), bus address, write data, expected value
// Expected value is the read data for a read and the o_gpo value after a write
1 C00000 11223344 00000000
1 C0041F 55667788 00000000
1 C00210 DEADBEEF 00000000
1 C00420 123456A7 00000000
1 C02421 0000003C 00000000
1 C01420 FFFFFF81 00000000
1 C02422 FFFFFF5A 00000000
1 C02521 000001C3 00000000
1 C024A2 00000077 00000000
0 C00000 00000000 11223344
0 C0041F 00000000 55667788
0 C00210 00000000 DEADBEEF
0 C00420 00000000 000000A7
0 C02421 00000000 0000003C
0 C01420 00000000 00000081
0 C02422 00000000 0000015A
0 C02521 00000000 000001C3
0 C024A2 00000000 00000077
1 C0041F 0BADF00D 00000000
0 C0041F 00000000 0BADF00D
0 C00420 00000000 000000A7
1 C02421 12345678 00000000
0 C02421 00000000 00000078
0 C02422 00000000 0000015A
0 C02522 00000000 00000000
0 C02523 00000000 01010101
0 C025A1 00000000 7F7F7F7F
0 C02622 00000000 01010100
0 C02721 00000000 010100FF
1 C02523 FFFFFFFF 00000000
0 C02523 00000000 01010101
0 C02737 00000000 0000000A
1 C02737 000000C0 0000000C
0 C02737 00000000 000000CA
1 C02737 FFFFFF3F 00000003
0 C02737 00000000 0000003A
0 C02741 00000000 00000001
1 C02741 FFFFFFFF 00000003
0 C02741 00000000 00000001
0 0000100 00000000 00000000
0 C02730 00000000 00000000
0 C02742 00000000 00000000
0 C02722 00000000 00000000
0 BFFFFF 00000000 00000000
0 7FFFFFF 00000000 00000000
1 C02742 FFFFFFFF 00000003
0 C02737 00000000 0000003A

/* compile.f */
+incdir+bench
source/mem_unit_pkg.sv
source/bus_decoder.sv
source/request_stage.sv
source/response_stage.sv
source/memory_unit.sv
bench/tb_memory_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build the memory unit testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_memory_unit -f compile.f &&
./obj_dir/Vtb_memory_unit | tee /dev/stderr | grep -q -F "Finished with no errors" &&
echo "PASS: memory unit simulation" ||
{ echo "FAIL: memory unit simulation"; exit 1; }
